// ==== enqueue_agent.sv ====
module enqueue_agent
    import eq_pkg::*;
(
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,

    // packet beats from the pipeline
    input  logic                  s_axis_tvalid,
    input  logic                  s_axis_tlast,
    input  logic                  s_axis_tpifo_valid,
    input  logic [TUSER_W-1:0]    s_axis_tuser,
    output logic                  s_axis_tready,

    // per queue status
    input  port_mask_t            s_axis_buffer_almost_full,
    input  port_mask_t            s_axis_pifo_full,

    // per queue controls
    output port_mask_t            m_axis_ctl_pifo_in_en,
    output port_mask_t            m_axis_ctl_buffer_wr_en,

    // cpu drop counter reads
    input  logic [AXI_ADDR_W-1:0] s_axi_addr,
    input  logic                  s_axi_req_valid,
    output cnt_t                  m_axi_data,
    output logic                  m_axi_resp_valid
);

    port_mask_t dst_mask;
    port_mask_t ready_mask;
    port_idx_t  src_idx;
    logic       drop_req;
    logic       drop_event;

    ////////////////////////////////////////
    // metadata decode
    ////////////////////////////////////////

    eq_port_decode i_port_decode
    (
        .tuser              (s_axis_tuser),
        .buffer_almost_full (s_axis_buffer_almost_full),
        .pifo_full          (s_axis_pifo_full),
        .dst_mask           (dst_mask),
        .ready_mask         (ready_mask),
        .src_idx            (src_idx),
        .drop_req           (drop_req)
    );

    ////////////////////////////////////////
    // enqueue / drop control
    ////////////////////////////////////////

    eq_agent_fsm i_agent_fsm
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .tvalid       (s_axis_tvalid),
        .tlast        (s_axis_tlast),
        .tpifo_valid  (s_axis_tpifo_valid),
        .drop_req     (drop_req),
        .ready_mask   (ready_mask),
        .tready       (s_axis_tready),
        .pifo_in_en   (m_axis_ctl_pifo_in_en),
        .buffer_wr_en (m_axis_ctl_buffer_wr_en),
        .drop_event   (drop_event)
    );

    ////////////////////////////////////////
    // drop statistics
    ////////////////////////////////////////

    eq_drop_stats i_drop_stats
    (
        .axis_aclk      (axis_aclk),
        .axis_resetn    (axis_resetn),
        .drop_event     (drop_event),
        .dst_mask       (dst_mask),
        .src_idx        (src_idx),
        .axi_addr       (s_axi_addr),
        .axi_req_valid  (s_axi_req_valid),
        .axi_data       (m_axi_data),
        .axi_resp_valid (m_axi_resp_valid)
    );

endmodule

// ==== eq_agent_fsm.sv ====
module eq_agent_fsm
    import eq_pkg::*;
(
    input  logic       axis_aclk,
    input  logic       axis_resetn,
    input  logic       tvalid,
    input  logic       tlast,
    input  logic       tpifo_valid,
    input  logic       drop_req,
    input  port_mask_t ready_mask,
    output logic       tready,
    output port_mask_t pifo_in_en,
    output port_mask_t buffer_wr_en,
    output logic       drop_event
);

    eq_state_e  state;
    eq_state_e  state_next;
    logic       tready_next;
    port_mask_t pifo_in_en_next;
    port_mask_t buffer_wr_en_next;
    logic       no_queue_free;

    ////////////////////////////////////////
    // drop decision
    ////////////////////////////////////////

    assign no_queue_free = (ready_mask == '0);

    // taken once per packet, on the first valid beat seen in IDLE
    assign drop_event = (state == IDLE) && tvalid &&
                        (drop_req || !tpifo_valid || no_queue_free);

    ////////////////////////////////////////
    // next state and enables
    ////////////////////////////////////////

    always_comb
    begin
        state_next        = state;
        pifo_in_en_next   = pifo_in_en;
        buffer_wr_en_next = buffer_wr_en;

        // ready follows any active state by one cycle
        tready_next = (state != IDLE);

        case (state)
            IDLE:
            begin
                pifo_in_en_next   = '0;
                buffer_wr_en_next = '0;
                if (tvalid)
                begin
                    if (drop_event)
                    begin
                        state_next = DROP;
                    end
                    else
                    begin
                        state_next = ENQUEUE_SOP;
                    end
                end
            end

            // metadata still stable here, sample free queues once
            ENQUEUE_SOP:
            begin
                pifo_in_en_next   = ready_mask;
                buffer_wr_en_next = ready_mask;
                state_next        = ENQUEUE_REMAIN;
            end

            ENQUEUE_REMAIN:
            begin
                // single insert per packet
                pifo_in_en_next = '0;
                if (tlast)
                begin
                    buffer_wr_en_next = '0;
                    state_next        = IDLE;
                end
            end

            DROP:
            begin
                // swallow beats until eop, enables stay low
                if (tlast)
                begin
                    state_next = IDLE;
                end
            end

            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state        <= IDLE;
            tready       <= 1'b0;
            pifo_in_en   <= '0;
            buffer_wr_en <= '0;
        end
        else
        begin
            state        <= state_next;
            tready       <= tready_next;
            pifo_in_en   <= pifo_in_en_next;
            buffer_wr_en <= buffer_wr_en_next;
        end
    end

endmodule

// ==== eq_drop_stats.sv ====
module eq_drop_stats
    import eq_pkg::*;
(
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,
    input  logic                  drop_event,
    input  port_mask_t            dst_mask,
    input  port_idx_t             src_idx,
    input  logic [AXI_ADDR_W-1:0] axi_addr,
    input  logic                  axi_req_valid,
    output cnt_t                  axi_data,
    output logic                  axi_resp_valid
);

    // cnt[dst][src] counts drops headed to dst that came from src
    cnt_t cnt [QUEUE_NUM][QUEUE_NUM];

    logic [ADDR_NIB_W-1:0] addr_src;
    logic [ADDR_NIB_W-1:0] addr_dst;
    port_idx_t             rd_dst;
    cnt_t                  rd_data;

    ////////////////////////////////////////
    // drop counters
    ////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            for (int d = 0; d < QUEUE_NUM; d++)
            begin
                for (int s = 0; s < QUEUE_NUM; s++)
                begin
                    cnt[d][s] <= '0;
                end
            end
        end
        else if (drop_event)
        begin
            // multicast drop bumps every named destination
            for (int d = 0; d < QUEUE_NUM; d++)
            begin
                if (dst_mask[d])
                begin
                    cnt[d][src_idx] <= cnt[d][src_idx] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // cpu read mux
    ////////////////////////////////////////

    assign addr_src = axi_addr[AXI_ADDR_W-1 -: ADDR_NIB_W];
    assign addr_dst = axi_addr[ADDR_NIB_W-1:0];

    // dst nibble 4 and up all land on the cpu queue
    assign rd_dst = (addr_dst >= CPU_PORT) ? CPU_PORT : addr_dst[IDX_W-1:0];

    always_comb
    begin
        rd_data = '0;
        // no row past the cpu source, read as zero
        if (addr_src <= CPU_PORT)
        begin
            rd_data = cnt[rd_dst][addr_src[IDX_W-1:0]];
        end
    end

    // response one cycle after request, data sampled every cycle
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            axi_data       <= '0;
            axi_resp_valid <= 1'b0;
        end
        else
        begin
            axi_data       <= rd_data;
            axi_resp_valid <= axi_req_valid;
        end
    end

endmodule

// ==== eq_pkg.sv ====
package eq_pkg;

    ////////////////////////////////////////
    // queue and index sizing
    ////////////////////////////////////////

    // four NF queues plus the CPU queue
    localparam int QUEUE_NUM = 5;

    // bits needed to index a queue or a source row
    localparam int IDX_W = 3;

    ////////////////////////////////////////
    // metadata layout
    ////////////////////////////////////////

    // full sume metadata width
    localparam int TUSER_W = 128;

    // src and dst are interleaved one-hot fields
    // {DMA, NF3, DMA, NF2, DMA, NF1, DMA, NF0}
    localparam int FIELD_W = 8;
    localparam int SRC_POS = 16;
    localparam int DST_POS = 24;

    // only the low bit of the drop byte is used
    localparam int DROP_POS = 32;

    ////////////////////////////////////////
    // cpu read port
    ////////////////////////////////////////

    localparam int AXI_DATA_W = 32;
    localparam int AXI_ADDR_W = 8;

    // address is {src nibble, dst nibble}
    localparam int ADDR_NIB_W = 4;

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////

    // one bit per output queue
    typedef logic [QUEUE_NUM-1:0] port_mask_t;

    // queue or source index
    typedef logic [IDX_W-1:0] port_idx_t;

    // drop counter, wraps on overflow
    typedef logic [AXI_DATA_W-1:0] cnt_t;

    // CPU queue also takes every DMA bit and unknown sources
    localparam port_idx_t CPU_PORT = 3'd4;

    // enqueue agent states
    typedef enum logic [1:0]
    {
        IDLE           = 2'd0,
        ENQUEUE_SOP    = 2'd1,
        ENQUEUE_REMAIN = 2'd2,
        DROP           = 2'd3
    } eq_state_e;

endpackage

// ==== eq_port_decode.sv ====
module eq_port_decode
    import eq_pkg::*;
(
    input  logic [TUSER_W-1:0] tuser,
    input  port_mask_t         buffer_almost_full,
    input  port_mask_t         pifo_full,
    output port_mask_t         dst_mask,
    output port_mask_t         ready_mask,
    output port_idx_t          src_idx,
    output logic               drop_req
);

    logic [FIELD_W-1:0] dst_field;
    logic [FIELD_W-1:0] src_field;
    logic               dma_any;

    assign dst_field = tuser[DST_POS +: FIELD_W];
    assign src_field = tuser[SRC_POS +: FIELD_W];

    ////////////////////////////////////////
    // destination decode
    ////////////////////////////////////////

    // odd bits are DMA, all of them fold onto the cpu queue
    assign dma_any = dst_field[1] | dst_field[3] | dst_field[5] | dst_field[7];

    always_comb
    begin
        dst_mask           = '0;
        dst_mask[0]        = dst_field[0];
        dst_mask[1]        = dst_field[2];
        dst_mask[2]        = dst_field[4];
        dst_mask[3]        = dst_field[6];
        dst_mask[CPU_PORT] = dma_any;
    end

    // drop queues that cannot take another packet
    assign ready_mask = dst_mask & ~buffer_almost_full & ~pifo_full;

    ////////////////////////////////////////
    // source row and drop bit
    ////////////////////////////////////////

    always_comb
    begin
        case (src_field)
            8'h01:   src_idx = 3'd0;
            8'h04:   src_idx = 3'd1;
            8'h10:   src_idx = 3'd2;
            8'h40:   src_idx = 3'd3;
            // dma and anything unexpected
            default: src_idx = CPU_PORT;
        endcase
    end

    assign drop_req = tuser[DROP_POS];

endmodule

// ==== flist.f ====
eq_pkg.sv
eq_port_decode.sv
eq_agent_fsm.sv
eq_drop_stats.sv
enqueue_agent.sv
tb_enqueue_agent.sv

// ==== tb_enqueue_agent.sv ====
module tb_enqueue_agent
    import eq_pkg::*;
();

    localparam int PERIOD    = 8;
    localparam int NUM_ENQ   = 24;
    localparam int NUM_DROP  = 24;
    localparam int NUM_MIX   = 20;
    localparam int NUM_DMA   = 8;
    localparam int MAX_BEATS = 8;
    localparam int MAX_PKTS  = NUM_ENQ + NUM_DROP + NUM_MIX + NUM_DMA;
    // per packet beats plus idle wait, four full read sweeps, reset
    localparam int WATCHDOG_TIME = (MAX_PKTS * (MAX_BEATS + 20) + 4 * 300 + 100) * PERIOD;

    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_SOP  = 2'd1;
    localparam logic [1:0] PH_BODY = 2'd2;
    localparam logic [1:0] PH_DROP = 2'd3;

    logic                  axis_aclk = 1'b0;
    logic                  axis_resetn;
    logic                  s_axis_tvalid;
    logic                  s_axis_tlast;
    logic                  s_axis_tpifo_valid;
    logic [TUSER_W-1:0]    s_axis_tuser;
    logic                  s_axis_tready;
    port_mask_t            s_axis_buffer_almost_full;
    port_mask_t            s_axis_pifo_full;
    port_mask_t            m_axis_ctl_pifo_in_en;
    port_mask_t            m_axis_ctl_buffer_wr_en;
    logic [AXI_ADDR_W-1:0] s_axi_addr;
    logic                  s_axi_req_valid;
    cnt_t                  m_axi_data;
    logic                  m_axi_resp_valid;

    int          errors = 0;
    int          checks = 0;
    int          packets = 0;
    int          reads = 0;
    logic [31:0] rng_state = 32'h75f8;

    enqueue_agent i_dut (.*);

    always #(PERIOD / 2) axis_aclk = ~axis_aclk;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    logic [1:0] m_phase;
    logic       exp_tready;
    port_mask_t exp_pifo;
    port_mask_t exp_wr;
    logic       exp_resp_valid;
    cnt_t       exp_data;
    cnt_t       mcnt [5][5];
    port_mask_t m_dst;
    port_mask_t m_ready;
    int         m_src;
    logic       m_drop;

    // even bits are NF queues and odd bits all fold onto the cpu queue
    function automatic port_mask_t dst_field_to_mask(input logic [7:0] f);
        port_mask_t m;
        m = '0;
        for (int i = 0; i < 4; i++)
        begin
            m[i] = f[2 * i];
            m[4] = m[4] | f[2 * i + 1];
        end
        return m;
    endfunction

    function automatic int src_field_to_row(input logic [7:0] f);
        int r;
        r = 4;
        for (int i = 0; i < 4; i++)
            if (f == (8'h01 << (2 * i)))
                r = i;
        return r;
    endfunction

    function automatic cnt_t expected_read_data(input logic [7:0] a);
        int s;
        int d;
        s = a[7:4];
        d = (a[3:0] > 4) ? 4 : a[3:0];
        if (s > 4)
            return '0;
        return mcnt[d][s];
    endfunction

    assign m_dst   = dst_field_to_mask(s_axis_tuser[DST_POS +: 8]);
    assign m_src   = src_field_to_row(s_axis_tuser[SRC_POS +: 8]);
    assign m_ready = m_dst & ~s_axis_buffer_almost_full & ~s_axis_pifo_full;
    assign m_drop  = s_axis_tuser[DROP_POS] || !s_axis_tpifo_valid || (m_ready == '0);

    always @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            m_phase        <= PH_IDLE;
            exp_tready     <= 1'b0;
            exp_pifo       <= '0;
            exp_wr         <= '0;
            exp_resp_valid <= 1'b0;
            exp_data       <= '0;
            for (int d = 0; d < 5; d++)
                for (int s = 0; s < 5; s++)
                    mcnt[d][s] <= '0;
        end
        else
        begin
            exp_tready     <= (m_phase != PH_IDLE);
            exp_resp_valid <= s_axi_req_valid;
            exp_data       <= expected_read_data(s_axi_addr);
            case (m_phase)
                PH_IDLE:
                    if (s_axis_tvalid && m_drop)
                    begin
                        m_phase <= PH_DROP;
                        for (int d = 0; d < 5; d++)
                            if (m_dst[d])
                                mcnt[d][m_src] <= mcnt[d][m_src] + 1;
                    end
                    else if (s_axis_tvalid)
                        m_phase <= PH_SOP;
                PH_SOP:
                begin
                    exp_pifo <= m_ready;
                    exp_wr   <= m_ready;
                    m_phase  <= PH_BODY;
                end
                PH_BODY:
                begin
                    exp_pifo <= '0;
                    if (s_axis_tlast)
                    begin
                        exp_wr  <= '0;
                        m_phase <= PH_IDLE;
                    end
                end
                default:
                    if (s_axis_tlast)
                        m_phase <= PH_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_tready: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        s_axis_tready == exp_tready)
        checks++;
    else
    begin
        errors++;
        $display("[ERROR] s_axis_tready expected %h got %h",
                 $sampled(exp_tready), $sampled(s_axis_tready));
    end

    a_pifo_in_en: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        m_axis_ctl_pifo_in_en == exp_pifo)
    else
    begin
        errors++;
        $display("[ERROR] m_axis_ctl_pifo_in_en expected %h got %h",
                 $sampled(exp_pifo), $sampled(m_axis_ctl_pifo_in_en));
    end

    a_buffer_wr_en: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        m_axis_ctl_buffer_wr_en == exp_wr)
    else
    begin
        errors++;
        $display("[ERROR] m_axis_ctl_buffer_wr_en expected %h got %h",
                 $sampled(exp_wr), $sampled(m_axis_ctl_buffer_wr_en));
    end

    a_resp_valid: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        m_axi_resp_valid == exp_resp_valid)
    else
    begin
        errors++;
        $display("[ERROR] m_axi_resp_valid expected %h got %h",
                 $sampled(exp_resp_valid), $sampled(m_axi_resp_valid));
    end

    a_data: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        m_axi_data == exp_data)
    else
    begin
        errors++;
        $display("[ERROR] m_axi_data expected %h got %h",
                 $sampled(exp_data), $sampled(m_axi_data));
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [TUSER_W-1:0] make_meta(input logic [7:0] dst,
                                                     input logic [7:0] src, input logic drop);
        logic [TUSER_W-1:0] m;
        m = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        m[DST_POS +: 8] = dst;
        m[SRC_POS +: 8] = src;
        m[DROP_POS]     = drop;
        return m;
    endfunction

    // mostly legal sources, some DMA and junk one-hots
    function automatic logic [7:0] pick_src();
        logic [31:0] r;
        r = lcg_next();
        case (r[30:28])
            3'd0:    return 8'h01;
            3'd1:    return 8'h04;
            3'd2:    return 8'h10;
            3'd3:    return 8'h40;
            3'd4:    return 8'h02;
            default: return r[15:8];
        endcase
    endfunction

    task automatic send_packet(input logic [TUSER_W-1:0] meta, input logic pv,
                               input port_mask_t af, input port_mask_t pf);
        int   beats;
        logic idle;
        beats = 3 + (lcg_next() >> 29) % (MAX_BEATS - 2);
        idle  = 1'b0;
        @(posedge axis_aclk);
        s_axis_tvalid             <= 1'b1;
        s_axis_tlast              <= 1'b0;
        s_axis_tuser              <= meta;
        s_axis_tpifo_valid        <= pv;
        s_axis_buffer_almost_full <= af;
        s_axis_pifo_full          <= pf;
        for (int b = 1; b < beats; b++)
        begin
            @(posedge axis_aclk);
            s_axis_tlast <= (b == beats - 1);
        end
        @(posedge axis_aclk);
        s_axis_tvalid <= 1'b0;
        s_axis_tlast  <= 1'b0;
        // tready falls once the agent is back in idle
        for (int i = 0; i < 16 && !idle; i++)
        begin
            @(negedge axis_aclk);
            idle = !s_axis_tready;
        end
        if (!idle)
        begin
            errors++;
            $display("agent did not return to idle after packet %0d", packets);
        end
        packets++;
    endtask

    // sweeps every address back to back
    task automatic read_all();
        for (int a = 0; a < 256; a++)
        begin
            @(posedge axis_aclk);
            s_axi_addr      <= a[7:0];
            s_axi_req_valid <= 1'b1;
            reads++;
        end
        @(posedge axis_aclk);
        s_axi_req_valid <= 1'b0;
        repeat (3) @(posedge axis_aclk);
    endtask

    initial
    begin
        logic [7:0] dst;
        port_mask_t af;
        port_mask_t pf;
        port_mask_t lo;
        logic [7:0] dma_list [NUM_DMA];
        dma_list = '{8'h02, 8'h08, 8'h20, 8'h80, 8'haa, 8'h03, 8'h5a, 8'hff};
        axis_resetn               = 1'b0;
        s_axis_tvalid             = 1'b0;
        s_axis_tlast              = 1'b0;
        s_axis_tpifo_valid        = 1'b0;
        s_axis_tuser              = '0;
        s_axis_buffer_almost_full = '0;
        s_axis_pifo_full          = '0;
        s_axi_addr                = '0;
        s_axi_req_valid           = 1'b0;
        repeat (8) @(posedge axis_aclk);
        axis_resetn <= 1'b1;
        read_all();

        // enqueues first and then each drop cause in turn
        for (int i = 0; i < NUM_ENQ + NUM_DROP; i++)
        begin
            dst = lcg_next() >> 24;
            dst = (dst == 8'h00) ? 8'h01 : dst;
            af  = lcg_next() >> 27;
            pf  = lcg_next() >> 27;
            lo  = dst_field_to_mask(dst) & (~dst_field_to_mask(dst) + 1'b1);
            af  = af & ~lo;
            pf  = pf & ~lo;
            if (i < NUM_ENQ)
                send_packet(make_meta(dst, pick_src(), 1'b0), 1'b1, af, pf);
            else if (i % 3 == 0)
                send_packet(make_meta(dst, pick_src(), 1'b1), 1'b1, af, pf);
            else if (i % 3 == 1)
                send_packet(make_meta(dst, pick_src(), 1'b0), 1'b0, af, pf);
            else
                send_packet(make_meta(dst, pick_src(), 1'b0), 1'b1,
                            af | dst_field_to_mask(dst), pf);
            if (i == NUM_ENQ - 1)
                read_all();
        end

        // dma bits fold onto queue 4
        for (int i = 0; i < NUM_DMA; i++)
            send_packet(make_meta(dma_list[i], pick_src(), 1'b0), 1'b1, '0, '0);
        read_all();

        // anything goes
        for (int i = 0; i < NUM_MIX; i++)
            send_packet(make_meta(lcg_next() >> 24, pick_src(), lcg_next() > 32'he000_0000),
                        lcg_next() > 32'h2000_0000, lcg_next() >> 27, lcg_next() >> 27);
        read_all();

        $display("packets %0d, cpu reads %0d, checks %0d, errors %0d",
                 packets, reads, checks, errors);
        if (errors == 0 && checks > 0)
            $display("all tests passed");
        else
        begin
            if (checks == 0)
                $display("no assertion was evaluated during the run");
            $display("tests failed");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("timeout, the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("tests failed");
        $finish;
    end

endmodule
